/* Bender.yml */
package:
  name: pkt_sync

sources:
  - source/pkt_sync_pkg.sv
  - source/stream_decoder.sv
  - source/stream_sync.sv
  - source/sync_stats.sv
  - source/pkt_sync_top.sv
  - target: test
    files:
      - dv/tb_clock_gen.sv
      - dv/pkt_sync_checker.sv
      - dv/pkt_sync_tb.sv

/* dv/pkt_sync_checker.sv */
// --------------------------------------------------------------------------
// Packet sync protocol checker
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module pkt_sync_checker #(
   parameter int DATA_WID = pkt_sync_pkg::DATA_WID,
   parameter int PTR_LEN  = pkt_sync_pkg::PTR_LEN_DEF
) (
   input logic                               clk,
   input logic                               arst_n,
   input logic                               in0_tvalid, in0_tready, in0_tlast,
   input logic                               in1_tvalid, in1_tready, in1_tlast,
   input logic                               out0_tvalid, out0_tready, out0_tlast,
   input logic                               out1_tvalid, out1_tready, out1_tlast,
   input logic [DATA_WID-1:0]                in0_tdata, in1_tdata, out0_tdata, out1_tdata,
   input logic [DATA_WID/8-1:0]              in0_tkeep, in1_tkeep, out0_tkeep, out1_tkeep,
   input logic [pkt_sync_pkg::TUSER_WID-1:0] in0_tuser, in1_tuser, out0_tuser, out1_tuser,
   input logic [pkt_sync_pkg::CNT_WID-1:0]   pair_count, mismatch_count,
   input logic [pkt_sync_pkg::CNT_WID-1:0]   stall0_count, stall1_count,
   input logic                               mismatch_seen
);

   // failed assertions so far, read by the testbench.
   int unsigned err_cnt = 0;

   logic sop0;
   logic sop1;
   logic fire0;
   logic fire1;
   logic aligned;
   logic id_diff;
   logic same0;
   logic same1;

   // framing rebuilt from the ingress handshake.
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         sop0 <= 1'b1;
         sop1 <= 1'b1;
      end else begin
         if (in0_tvalid && in0_tready) begin
            sop0 <= in0_tlast;
         end
         if (in1_tvalid && in1_tready) begin
            sop1 <= in1_tlast;
         end
      end
   end

   // a first word actually leaving on this edge.
   assign fire0   = sop0 && in0_tvalid && in0_tready;
   assign fire1   = sop1 && in1_tvalid && in1_tready;
   assign aligned = sop0 && sop1 && in0_tvalid && in1_tvalid;
   assign id_diff = (in0_tuser[PTR_LEN-1:0] != in1_tuser[PTR_LEN-1:0]);

   // egress fields equal the ingress fields of the same cycle.
   assign same0 = (out0_tdata == in0_tdata) && (out0_tkeep == in0_tkeep) &&
                  (out0_tlast == in0_tlast) && (out0_tuser == in0_tuser);
   assign same1 = (out1_tdata == in1_tdata) && (out1_tkeep == in1_tkeep) &&
                  (out1_tlast == in1_tlast) && (out1_tuser == in1_tuser);

   // --------------------------------------------------------------------------
   // assertions
   // --------------------------------------------------------------------------

   a_pair: assert property (@(posedge clk) disable iff (!arst_n)
         (fire0 || fire1) |-> (fire0 && fire1))
      else begin
         $error("first words of a packet pair did not transfer together");
         err_cnt++;
      end

   a_pass: assert property (@(posedge clk) disable iff (!arst_n)
         (!(out0_tvalid && out0_tready) || same0) && (!(out1_tvalid && out1_tready) || same1))
      else begin
         $error("egress word differs from the ingress word");
         err_cnt++;
      end

   // mid packet, each stream follows its own egress ready.
   a_mid: assert property (@(posedge clk) disable iff (!arst_n)
         (sop0 || !in0_tvalid || (out0_tvalid && (in0_tready == out0_tready))) &&
         (sop1 || !in1_tvalid || (out1_tvalid && (in1_tready == out1_tready))))
      else begin
         $error("mid-packet stream was held by the other stream");
         err_cnt++;
      end

   // a first word shows on an output only when its pair can leave.
   // skew, back-pressure or differing ids keep both first words back.
   a_hold: assert property (@(posedge clk) disable iff (!arst_n)
         (!aligned || id_diff || !out0_tready || !out1_tready) |->
         (!(sop0 && out0_tvalid) && !(sop1 && out1_tvalid)))
      else begin
         $error("first word valid at a start that cannot be released");
         err_cnt++;
      end

   a_flag: assert property (@(posedge clk) disable iff (!arst_n)
         (mismatch_seen || (aligned && id_diff)) |=> mismatch_seen)
      else begin
         $error("mismatch flag did not rise or did not stay high");
         err_cnt++;
      end

   a_idle: assert property (@(posedge clk) disable iff (!arst_n)
         (in0_tvalid || !out0_tvalid) && (in1_tvalid || !out1_tvalid))
      else begin
         $error("output valid while its input is idle");
         err_cnt++;
      end

   // statistics read zero on the edge after each reset cycle.
   a_reset: assert property (@(posedge clk)
         !arst_n |=> (pair_count == '0) && (mismatch_count == '0) && (stall0_count == '0) &&
         (stall1_count == '0) && !mismatch_seen)
      else begin
         $error("statistics not cleared by reset");
         err_cnt++;
      end

endmodule

bind pkt_sync_top pkt_sync_checker #(.DATA_WID(DATA_WID), .PTR_LEN(PTR_LEN)) chk (.*);

/* dv/pkt_sync_tb.sv */
// --------------------------------------------------------------------------
// Packet stream sync testbench
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module pkt_sync_tb;

   import pkt_sync_pkg::*;

   // cycle budget of each test in run order, plus a margin.
   localparam int RUN_LIMIT = 10 + 80 + 80 + 200 + 30 + 30 + 200;

   logic                 clk;
   logic                 arst_n;
   logic                 in0_tvalid, in0_tready, in0_tlast;
   logic                 in1_tvalid, in1_tready, in1_tlast;
   logic                 out0_tvalid, out0_tready, out0_tlast;
   logic                 out1_tvalid, out1_tready, out1_tlast;
   logic [DATA_WID-1:0]  in0_tdata, in1_tdata, out0_tdata, out1_tdata;
   logic [DATA_WID/8-1:0] in0_tkeep, in1_tkeep, out0_tkeep, out1_tkeep;
   logic [TUSER_WID-1:0] in0_tuser, in1_tuser, out0_tuser, out1_tuser;
   logic [CNT_WID-1:0]   pair_count, mismatch_count, stall0_count, stall1_count;
   logic                 mismatch_seen;

   // word entry: idle, first, last, tuser[15:8], packet id, tdata.
   logic [50:0] q0[$];
   logic [50:0] q1[$];
   bit          on0, on1;
   bit          first0, first1;
   bit          rnd1;
   int          low0;
   int          exp_pair, exp_mm, exp_st0, exp_st1, exp_seen;
   int          errors, checks, tests, err_base;
   int          cycles = 0;

   tb_clock_gen #(.PERIOD_NS(20), .RST_CYCLES(2)) clk_gen (.clk(clk), .arst_n(arst_n));

   pkt_sync_top #(.DATA_WID(DATA_WID), .PTR_LEN(PTR_LEN_DEF)) UUT (.*);

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= RUN_LIMIT) begin
         $display("run stopped: cycle limit of %0d reached", RUN_LIMIT);
         $display("Result: FAILED");
         $finish;
      end
   end

   // --------------------------------------------------------------------------
   // stimulus helpers
   // --------------------------------------------------------------------------

   task automatic queue_word(input bit s, input logic [50:0] w);
      if (s) begin
         q1.push_back(w);
      end else begin
         q0.push_back(w);
      end
   endtask

   // gap idle cycles, then one packet of len words.
   task automatic push_pkt(input bit s, input int len, input logic [7:0] id, input int gap);
      for (int g = 0; g < gap; g++) begin
         queue_word(s, {1'b1, 50'd0});
      end
      for (int i = 0; i < len; i++) begin
         queue_word(s, {1'b0, 1'(i == 0), 1'(i == len - 1), 8'($urandom), id, 32'($urandom)});
      end
   endtask

   // one clock: account the cycle just ended, then drive the next one.
   task automatic step();
      logic a0;
      logic a1;
      logic same_id;
      logic rel;
      @(posedge clk);
      // expected events, from the gating rule and what was driven.
      a0      = in0_tvalid && first0;
      a1      = in1_tvalid && first1;
      same_id = (in0_tuser[PTR_LEN_DEF-1:0] == in1_tuser[PTR_LEN_DEF-1:0]);
      rel     = a0 && a1 && same_id && out0_tready && out1_tready;
      exp_pair += rel;
      exp_st0  += a0 && !rel;
      exp_st1  += a1 && !rel;
      if (a0 && a1 && !same_id) begin
         exp_mm++;
         exp_seen = 1;
      end
      // stream 0 source.
      if (on0 && (q0[0][50] || (in0_tvalid && in0_tready))) begin
         void'(q0.pop_front());
         on0 = 1'b0;
      end
      if (!on0 && q0.size() != 0) begin
         in0_tvalid <= !q0[0][50];
         in0_tlast  <= q0[0][48];
         in0_tuser  <= q0[0][47:32];
         in0_tdata  <= q0[0][31:0];
         in0_tkeep  <= q0[0][DATA_WID/8-1:0];
         first0     = q0[0][49] && !q0[0][50];
         on0        = 1'b1;
      end else if (!on0) begin
         in0_tvalid <= 1'b0;
         first0     = 1'b0;
      end
      // stream 1 source.
      if (on1 && (q1[0][50] || (in1_tvalid && in1_tready))) begin
         void'(q1.pop_front());
         on1 = 1'b0;
      end
      if (!on1 && q1.size() != 0) begin
         in1_tvalid <= !q1[0][50];
         in1_tlast  <= q1[0][48];
         in1_tuser  <= q1[0][47:32];
         in1_tdata  <= q1[0][31:0];
         in1_tkeep  <= q1[0][DATA_WID/8-1:0];
         first1     = q1[0][49] && !q1[0][50];
         on1        = 1'b1;
      end else if (!on1) begin
         in1_tvalid <= 1'b0;
         first1     = 1'b0;
      end
      // egress ready, stream 1 toggles only mid packet.
      out0_tready <= (low0 == 0);
      if (low0 > 0) begin
         low0--;
      end
      if (rnd1 && on1 && !first1) begin
         out1_tready <= ($urandom % 2) != 0;
      end else begin
         out1_tready <= 1'b1;
      end
   endtask

   task automatic drain();
      while (q0.size() != 0 || q1.size() != 0) begin
         step();
      end
      repeat (2) step();
   endtask

   task automatic check_value(input string name, input int exp, input int got);
      checks++;
      if (exp != got) begin
         errors++;
         $display("CHECK FAILED %s: expected 0x%0h observed 0x%0h", name, exp, got);
      end
   endtask

   task automatic end_test(input string name);
      int now;
      // counters are settled half a cycle after the last edge.
      @(negedge clk);
      check_value("pair_count", exp_pair, pair_count);
      check_value("mismatch_count", exp_mm, mismatch_count);
      check_value("stall0_count", exp_st0, stall0_count);
      check_value("stall1_count", exp_st1, stall1_count);
      check_value("mismatch_seen", exp_seen, mismatch_seen);
      now = errors + UUT.chk.err_cnt;
      tests++;
      $display("test %0d %s: %0d errors", tests, name, now - err_base);
      err_base = now;
   endtask

   // --------------------------------------------------------------------------
   // test sequence
   // --------------------------------------------------------------------------

   initial begin
      void'($urandom(54038));
      in0_tvalid  <= 1'b0;
      in0_tlast   <= 1'b0;
      in0_tdata   <= '0;
      in0_tkeep   <= '0;
      in0_tuser   <= '0;
      in1_tvalid  <= 1'b0;
      in1_tlast   <= 1'b0;
      in1_tdata   <= '0;
      in1_tkeep   <= '0;
      in1_tuser   <= '0;
      out0_tready <= 1'b1;
      out1_tready <= 1'b1;
      @(posedge arst_n);
      repeat (4) step();
      end_test("reset state");
      // stream 1 trails stream 0 by a few idle cycles per packet.
      for (int k = 0; k < 3; k++) begin
         push_pkt(0, 1 + $urandom % 6, 8'(k + 1), 0);
         push_pkt(1, 1 + $urandom % 6, 8'(k + 1), 2 + k);
      end
      drain();
      end_test("skewed start");
      for (int k = 0; k < 4; k++) begin
         push_pkt(0, 1 + $urandom % 6, 8'(16 + k), $urandom % 4);
         push_pkt(1, 1 + $urandom % 6, 8'(16 + k), $urandom % 4);
      end
      drain();
      end_test("pass-through");
      // long payload packets with a wavering egress ready.
      rnd1 = 1'b1;
      for (int k = 0; k < 5; k++) begin
         push_pkt(0, 1 + $urandom % 4, 8'(32 + k), 0);
         push_pkt(1, 2 + $urandom % 7, 8'(32 + k), 0);
      end
      drain();
      rnd1 = 1'b0;
      end_test("mid-packet independence");
      low0 = 5;
      push_pkt(0, 3, 8'h30, 0);
      push_pkt(1, 3, 8'h30, 0);
      drain();
      end_test("back-pressure at start");
      // differing ids park both streams until the payload id is fixed.
      push_pkt(0, 3, 8'h40, 0);
      push_pkt(1, 3, 8'h41, 0);
      repeat (6) step();
      q1[0][39:32] = 8'h40;
      on1 = 1'b0;
      drain();
      end_test("id mismatch");
      $display("tests %0d, checks %0d, check errors %0d, assertion errors %0d",
               tests, checks, errors, UUT.chk.err_cnt);
      if (errors == 0 && UUT.chk.err_cnt == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

/* dv/tb_clock_gen.sv */
// --------------------------------------------------------------------------
// Testbench clock and reset
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module tb_clock_gen #(
   parameter int PERIOD_NS  = 20,
   parameter int RST_CYCLES = 2
) (
   output logic clk,
   output logic arst_n
);

   initial begin
      clk    = 1'b0;
      arst_n = 1'b0;
      // release lands on a falling edge, away from the sampling edge.
      #(PERIOD_NS * RST_CYCLES);
      arst_n = 1'b1;
   end

   always #(PERIOD_NS / 2) clk = ~clk;

endmodule

/* list.f */
source/pkt_sync_pkg.sv
source/stream_decoder.sv
source/stream_sync.sv
source/sync_stats.sv
source/pkt_sync_top.sv
dv/tb_clock_gen.sv
dv/pkt_sync_checker.sv
dv/pkt_sync_tb.sv

/* source/pkt_sync_pkg.sv */
// --------------------------------------------------------------------------
// Packet sync shared definitions
// --------------------------------------------------------------------------

package pkt_sync_pkg;

   // --------------------------------------------------------------------------
   // widths
   // --------------------------------------------------------------------------

   // default stream data width, in bits.
   localparam int DATA_WID = 32;

   // default packet id width, carried in the low bits of tuser.
   localparam int PTR_LEN_DEF = 8;

   // tuser width on both ingress and egress streams.
   localparam int TUSER_WID = 16;

   // width of the statistics counters and the word index.
   localparam int CNT_WID = 16;

   // --------------------------------------------------------------------------
   // tuser field positions
   // --------------------------------------------------------------------------

   // packet id starts at bit 0 of tuser.
   localparam int PID_LSB = 0;

   // --------------------------------------------------------------------------
   // packet framing state
   // --------------------------------------------------------------------------

   // idle waits for the first word of a packet.
   // in_pkt is anywhere after the first accepted word, up to tlast.
   typedef enum logic [0:0] {
      IDLE   = 1'b0,
      IN_PKT = 1'b1
   } pkt_state_e;

endpackage

/* source/pkt_sync_top.sv */
// --------------------------------------------------------------------------
// Packet stream sync top
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module pkt_sync_top #(
   parameter int DATA_WID = pkt_sync_pkg::DATA_WID,
   parameter int PTR_LEN  = pkt_sync_pkg::PTR_LEN_DEF
) (
   input  logic                            clk,
   input  logic                            arst_n,

   // ingress stream 0, header.
   input  logic                            in0_tvalid,
   output logic                            in0_tready,
   input  logic [DATA_WID-1:0]             in0_tdata,
   input  logic [DATA_WID/8-1:0]           in0_tkeep,
   input  logic                            in0_tlast,
   input  logic [pkt_sync_pkg::TUSER_WID-1:0] in0_tuser,

   // ingress stream 1, payload.
   input  logic                            in1_tvalid,
   output logic                            in1_tready,
   input  logic [DATA_WID-1:0]             in1_tdata,
   input  logic [DATA_WID/8-1:0]           in1_tkeep,
   input  logic                            in1_tlast,
   input  logic [pkt_sync_pkg::TUSER_WID-1:0] in1_tuser,

   // egress stream 0.
   output logic                            out0_tvalid,
   input  logic                            out0_tready,
   output logic [DATA_WID-1:0]             out0_tdata,
   output logic [DATA_WID/8-1:0]           out0_tkeep,
   output logic                            out0_tlast,
   output logic [pkt_sync_pkg::TUSER_WID-1:0] out0_tuser,

   // egress stream 1.
   output logic                            out1_tvalid,
   input  logic                            out1_tready,
   output logic [DATA_WID-1:0]             out1_tdata,
   output logic [DATA_WID/8-1:0]           out1_tkeep,
   output logic                            out1_tlast,
   output logic [pkt_sync_pkg::TUSER_WID-1:0] out1_tuser,

   // statistics.
   output logic [pkt_sync_pkg::CNT_WID-1:0]   pair_count,
   output logic [pkt_sync_pkg::CNT_WID-1:0]   mismatch_count,
   output logic [pkt_sync_pkg::CNT_WID-1:0]   stall0_count,
   output logic [pkt_sync_pkg::CNT_WID-1:0]   stall1_count,
   output logic                            mismatch_seen
);

   // --------------------------------------------------------------------------
   // internal wiring
   // --------------------------------------------------------------------------

   logic               sop0;
   logic               sop1;
   logic [PTR_LEN-1:0] pid0;
   logic [PTR_LEN-1:0] pid1;
   logic               sop_mismatch;
   logic               pair_fire;
   logic               stall0;
   logic               stall1;

   // decoders watch the gated handshake, so they see only real transfers.
   // word position is not needed here, left open.
   stream_decoder #(.DATA_WID(DATA_WID), .PTR_LEN(PTR_LEN)) dec0 (
      .clk        (clk),
      .arst_n     (arst_n),
      .tvalid     (in0_tvalid),
      .tready     (in0_tready),
      .tlast      (in0_tlast),
      .tuser      (in0_tuser),
      .sop        (sop0),
      .pid        (pid0),
      .word_index ()
   );

   stream_decoder #(.DATA_WID(DATA_WID), .PTR_LEN(PTR_LEN)) dec1 (
      .clk        (clk),
      .arst_n     (arst_n),
      .tvalid     (in1_tvalid),
      .tready     (in1_tready),
      .tlast      (in1_tlast),
      .tuser      (in1_tuser),
      .sop        (sop1),
      .pid        (pid1),
      .word_index ()
   );

   stream_sync #(.DATA_WID(DATA_WID), .PTR_LEN(PTR_LEN)) u_sync (
      .in0_tvalid   (in0_tvalid),   .in0_tready  (in0_tready),
      .in0_tdata    (in0_tdata),    .in0_tkeep   (in0_tkeep),
      .in0_tlast    (in0_tlast),    .in0_tuser   (in0_tuser),
      .in1_tvalid   (in1_tvalid),   .in1_tready  (in1_tready),
      .in1_tdata    (in1_tdata),    .in1_tkeep   (in1_tkeep),
      .in1_tlast    (in1_tlast),    .in1_tuser   (in1_tuser),
      .out0_tvalid  (out0_tvalid),  .out0_tready (out0_tready),
      .out0_tdata   (out0_tdata),   .out0_tkeep  (out0_tkeep),
      .out0_tlast   (out0_tlast),   .out0_tuser  (out0_tuser),
      .out1_tvalid  (out1_tvalid),  .out1_tready (out1_tready),
      .out1_tdata   (out1_tdata),   .out1_tkeep  (out1_tkeep),
      .out1_tlast   (out1_tlast),   .out1_tuser  (out1_tuser),
      .sop0         (sop0),         .sop1        (sop1),
      .pid0         (pid0),         .pid1        (pid1),
      .sop_mismatch (sop_mismatch), .pair_fire   (pair_fire),
      .stall0       (stall0),       .stall1      (stall1)
   );

   sync_stats u_stats (
      .clk            (clk),
      .arst_n         (arst_n),
      .pair_fire      (pair_fire),
      .sop_mismatch   (sop_mismatch),
      .stall0         (stall0),
      .stall1         (stall1),
      .pair_count     (pair_count),
      .mismatch_count (mismatch_count),
      .stall0_count   (stall0_count),
      .stall1_count   (stall1_count),
      .mismatch_seen  (mismatch_seen)
   );

endmodule

/* source/stream_decoder.sv */
// --------------------------------------------------------------------------
// Stream packet decoder
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module stream_decoder #(
   parameter int DATA_WID = pkt_sync_pkg::DATA_WID,
   parameter int PTR_LEN  = pkt_sync_pkg::PTR_LEN_DEF
) (
   input  logic                            clk,
   input  logic                            arst_n,

   // observed ingress handshake, tready is the gated one.
   input  logic                            tvalid,
   input  logic                            tready,
   input  logic                            tlast,
   input  logic [pkt_sync_pkg::TUSER_WID-1:0] tuser,

   // framing status.
   output logic                            sop,
   output logic [PTR_LEN-1:0]              pid,
   output logic [pkt_sync_pkg::CNT_WID-1:0]   word_index
);

   import pkt_sync_pkg::*;

   // --------------------------------------------------------------------------
   // elaboration checks
   // --------------------------------------------------------------------------

   // the id field must fit inside tuser.
   if (PID_LSB + PTR_LEN > TUSER_WID) begin : g_bad_ptr_len
      $error("stream_decoder: PTR_LEN %0d does not fit in tuser", PTR_LEN);
   end

   // streams are byte based, tkeep is one bit per byte.
   if ((DATA_WID % 8) != 0) begin : g_bad_data_wid
      $error("stream_decoder: DATA_WID %0d is not a whole number of bytes", DATA_WID);
   end

   // --------------------------------------------------------------------------
   // framing state
   // --------------------------------------------------------------------------

   pkt_state_e          state;
   pkt_state_e          state_nxt;
   logic                accept;
   logic [CNT_WID-1:0]  word_cnt;

   // a word moves only when both sides of the handshake agree.
   assign accept = tvalid && tready;

   always_comb begin
      state_nxt = state;
      if (accept) begin
         // tlast closes the packet, anything else keeps us inside one.
         if (tlast) begin
            state_nxt = IDLE;
         end else begin
            state_nxt = IN_PKT;
         end
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state <= IDLE;
      end else begin
         state <= state_nxt;
      end
   end

   // the next word seen in idle is a packet start.
   assign sop = (state == IDLE);

   // --------------------------------------------------------------------------
   // packet id and word position
   // --------------------------------------------------------------------------

   // id rides in the low field of tuser on every word.
   assign pid = tuser[PID_LSB +: PTR_LEN];

   // counts accepted words of the current packet.
   // held at its top value on very long packets.
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         word_cnt <= '0;
      end else if (accept) begin
         if (tlast) begin
            word_cnt <= '0;
         end else if (word_cnt != {CNT_WID{1'b1}}) begin
            word_cnt <= word_cnt + 1'b1;
         end
      end
   end

   // position of the word now on the bus, 0 at start of packet.
   assign word_index = word_cnt;

endmodule

/* source/stream_sync.sv */
// --------------------------------------------------------------------------
// Start of packet stream sync
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module stream_sync #(
   parameter int DATA_WID = pkt_sync_pkg::DATA_WID,
   parameter int PTR_LEN  = pkt_sync_pkg::PTR_LEN_DEF
) (
   // ingress stream 0, header.
   input  logic                            in0_tvalid,
   output logic                            in0_tready,
   input  logic [DATA_WID-1:0]             in0_tdata,
   input  logic [DATA_WID/8-1:0]           in0_tkeep,
   input  logic                            in0_tlast,
   input  logic [pkt_sync_pkg::TUSER_WID-1:0] in0_tuser,

   // ingress stream 1, payload.
   input  logic                            in1_tvalid,
   output logic                            in1_tready,
   input  logic [DATA_WID-1:0]             in1_tdata,
   input  logic [DATA_WID/8-1:0]           in1_tkeep,
   input  logic                            in1_tlast,
   input  logic [pkt_sync_pkg::TUSER_WID-1:0] in1_tuser,

   // egress stream 0.
   output logic                            out0_tvalid,
   input  logic                            out0_tready,
   output logic [DATA_WID-1:0]             out0_tdata,
   output logic [DATA_WID/8-1:0]           out0_tkeep,
   output logic                            out0_tlast,
   output logic [pkt_sync_pkg::TUSER_WID-1:0] out0_tuser,

   // egress stream 1.
   output logic                            out1_tvalid,
   input  logic                            out1_tready,
   output logic [DATA_WID-1:0]             out1_tdata,
   output logic [DATA_WID/8-1:0]           out1_tkeep,
   output logic                            out1_tlast,
   output logic [pkt_sync_pkg::TUSER_WID-1:0] out1_tuser,

   // framing from the decoders.
   input  logic                            sop0,
   input  logic                            sop1,
   input  logic [PTR_LEN-1:0]              pid0,
   input  logic [PTR_LEN-1:0]              pid1,

   // status strobes for the stats block.
   output logic                            sop_mismatch,
   output logic                            pair_fire,
   output logic                            stall0,
   output logic                            stall1
);

   // --------------------------------------------------------------------------
   // alignment and gating
   // --------------------------------------------------------------------------

   logic aligned;
   logic id_match;
   logic release_ok;
   logic gate0;
   logic gate1;

   // both streams show a valid first word in the same cycle.
   assign aligned  = sop0 && in0_tvalid && sop1 && in1_tvalid;
   assign id_match = (pid0 == pid1);

   // a pair leaves only when it matches and both egress sides take it.
   // a low tready on either side keeps both first words back.
   assign release_ok = aligned && id_match && out0_tready && out1_tready;

   // mid packet each gate stays open, so the stream follows its own tready.
   assign gate0 = !sop0 || release_ok;
   assign gate1 = !sop1 || release_ok;

   // differing ids at an aligned start never release, streams stay parked.
   assign sop_mismatch = aligned && !id_match;

   // both first words move on this edge.
   assign pair_fire = release_ok;

   // a stream waits at its start word.
   assign stall0 = sop0 && in0_tvalid && !gate0;
   assign stall1 = sop1 && in1_tvalid && !gate1;

   // --------------------------------------------------------------------------
   // stream 0 handshake and data
   // --------------------------------------------------------------------------

   assign out0_tvalid = in0_tvalid && gate0;
   assign in0_tready  = out0_tready && gate0;

   // payload passes straight through.
   assign out0_tdata  = in0_tdata;
   assign out0_tkeep  = in0_tkeep;
   assign out0_tlast  = in0_tlast;
   assign out0_tuser  = in0_tuser;

   // --------------------------------------------------------------------------
   // stream 1 handshake and data
   // --------------------------------------------------------------------------

   assign out1_tvalid = in1_tvalid && gate1;
   assign in1_tready  = out1_tready && gate1;

   assign out1_tdata  = in1_tdata;
   assign out1_tkeep  = in1_tkeep;
   assign out1_tlast  = in1_tlast;
   assign out1_tuser  = in1_tuser;

endmodule

/* source/sync_stats.sv */
// --------------------------------------------------------------------------
// Sync statistics counters
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module sync_stats (
   input  logic                          clk,
   input  logic                          arst_n,

   // event strobes from the sync stage.
   input  logic                          pair_fire,
   input  logic                          sop_mismatch,
   input  logic                          stall0,
   input  logic                          stall1,

   // statistics.
   output logic [pkt_sync_pkg::CNT_WID-1:0] pair_count,
   output logic [pkt_sync_pkg::CNT_WID-1:0] mismatch_count,
   output logic [pkt_sync_pkg::CNT_WID-1:0] stall0_count,
   output logic [pkt_sync_pkg::CNT_WID-1:0] stall1_count,
   output logic                          mismatch_seen
);

   import pkt_sync_pkg::*;

   // --------------------------------------------------------------------------
   // saturating increment
   // --------------------------------------------------------------------------

   // bumps cnt by one when ev is set, sticks at all ones.
   function automatic logic [CNT_WID-1:0] sat_inc(
      input logic [CNT_WID-1:0] cnt,
      input logic               ev
   );
      logic [CNT_WID-1:0] res;
      res = cnt;
      if (ev && (cnt != {CNT_WID{1'b1}})) begin
         res = cnt + 1'b1;
      end
      return res;
   endfunction

   // --------------------------------------------------------------------------
   // counters
   // --------------------------------------------------------------------------

   // each count shows its event one cycle after the strobe.
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         pair_count     <= '0;
         mismatch_count <= '0;
         stall0_count   <= '0;
         stall1_count   <= '0;
      end else begin
         pair_count     <= sat_inc(pair_count, pair_fire);
         // one count per cycle of mismatch, not per packet.
         mismatch_count <= sat_inc(mismatch_count, sop_mismatch);
         stall0_count   <= sat_inc(stall0_count, stall0);
         stall1_count   <= sat_inc(stall1_count, stall1);
      end
   end

   // --------------------------------------------------------------------------
   // sticky mismatch flag
   // --------------------------------------------------------------------------

   // set on the first mismatch, cleared only by reset.
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         mismatch_seen <= 1'b0;
      end else if (sop_mismatch) begin
         mismatch_seen <= 1'b1;
      end
   end

endmodule
